//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and instruction words share one width
`define CPU_WORD_W 16

// Register file shape
`define CPU_REG_COUNT 8
`define CPU_REG_ADDR_W 3

// Memory depths in words, PC and data addresses wrap at these
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// BL writes its return address here
`define CPU_LINK_REG 7

// First fetch address out of reset
`define CPU_PC_RESET 0

`endif

//--- cpuPkg.sv
`default_nettype none
`include "cpu_defines.svh"

package cpuPkg;

	// Machine words
	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [`CPU_WORD_W-1:0] instr_t;
	typedef logic [`CPU_REG_ADDR_W-1:0] regAddr_t;

	// Opcode sits in instr[15:12]
	// Field layout per class
	//   ADDI, SUBI    rd[11:9] rn[8:6] imm3[5:3] zero extended
	//   ALU, shifts   rd[11:9] rn[8:6] rm[5:3], shift amount is rm[3:0]
	//   MOVI          rd[11:9] imm8[7:0] zero extended
	//   LDR           rd[11:9] rn[8:6] off5[4:0], address rn + off5
	//   STR           rt[11:9] rn[8:6] off5[4:0], stores rt
	//   B, BL         off11[10:0] signed, relative to the branch PC
	//   BC            cond[11:8] off7[6:0] signed
	//   BX            rm[8:6], jumps to the register value
	typedef enum logic [3:0] {
		OP_ADDI = 4'h0,
		OP_SUBI = 4'h1,
		OP_ADD  = 4'h2,
		OP_SUB  = 4'h3,
		OP_AND  = 4'h4,
		OP_ORR  = 4'h5,
		OP_EOR  = 4'h6,
		OP_LSL  = 4'h7,
		OP_LSR  = 4'h8,
		OP_MOVI = 4'h9,
		OP_LDR  = 4'ha,
		OP_STR  = 4'hb,
		OP_B    = 4'hc,
		OP_BC   = 4'hd,
		OP_BL   = 4'he,
		OP_BX   = 4'hf
	} opcode_e;

	// ARM ordering; codes 8 and up never branch
	typedef enum logic [3:0] {
		COND_EQ = 4'h0,
		COND_NE = 4'h1,
		COND_CS = 4'h2,
		COND_CC = 4'h3,
		COND_MI = 4'h4,
		COND_PL = 4'h5,
		COND_VS = 4'h6,
		COND_VC = 4'h7
	} cond_e;

	typedef struct packed {
		logic negative;
		logic zero;
		logic carry;
		logic overflow;
	} aluFlags_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR,
		ALU_PASSB
	} aluOp_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_IMM,
		WB_LINK
	} wbSel_e;

	// Decoded controls for one instruction
	typedef struct packed {
		aluOp_e aluOp;
		logic bIsImm;
		logic regWrite;
		logic memWrite;
		logic setFlags;
		wbSel_e wbSel;
	} execCtrl_t;

	// Decode to execute pipeline register contents
	typedef struct packed {
		logic valid;
		execCtrl_t ctrl;
		word_t imm;
		word_t opA;
		word_t opB;
		regAddr_t writeAddr;
		word_t link;
	} execStage_t;

	// Mirror of every data memory write
	typedef struct packed {
		logic strobe;
		word_t addr;
		word_t data;
	} storeBus_t;

endpackage

`default_nettype wire

//--- wordRam.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module wordRam #(
	parameter type wordT = logic [`CPU_WORD_W-1:0],
	parameter int depth = 256,
	localparam int addrW = $clog2(depth)
) (
	input wire clk,
	input wire writeEnable,
	input wire [addrW-1:0] writeAddr,
	input wire wordT writeData,
	input wire [addrW-1:0] readAddr,
	output wordT readData
);

	wordT mem [0:depth-1];

	// Contents start cleared
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (writeEnable) begin
			mem[writeAddr] <= writeData;
		end
	end

	// Asynchronous read, a load sees its data in the same cycle
	assign readData = mem[readAddr];

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module regFile (
	input wire clk,
	input wire reset,
	input wire cpuPkg::regAddr_t readAddrA,
	input wire cpuPkg::regAddr_t readAddrB,
	output cpuPkg::word_t readDataA,
	output cpuPkg::word_t readDataB,
	input wire regWrite,
	input wire cpuPkg::regAddr_t writeAddr,
	input wire cpuPkg::word_t writeData
);
	import cpuPkg::*;

	word_t regs [0:`CPU_REG_COUNT-1];

	// Single write port, lands at the end of the execute cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Asynchronous reads, bypass is done in decode
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

//--- cpuControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpuControl (
	input wire clk,
	input wire reset,
	input wire cpuPkg::instr_t instr,
	output cpuPkg::word_t pc,
	output cpuPkg::regAddr_t readAddrA,
	output cpuPkg::regAddr_t readAddrB,
	input wire cpuPkg::word_t readDataA,
	input wire cpuPkg::word_t readDataB,
	input wire fwdValid,
	input wire cpuPkg::regAddr_t fwdAddr,
	input wire cpuPkg::word_t fwdData,
	input wire cpuPkg::aluFlags_t flagsNext,
	input wire flagsWillSet,
	input wire cpuPkg::aluFlags_t flags,
	output cpuPkg::execStage_t execStage
);
	import cpuPkg::*;

	// PC wraps inside instruction memory
	localparam word_t pcMask = word_t'(`CPU_IMEM_DEPTH - 1);

	opcode_e opcode;
	cond_e cond;
	word_t operandA;
	word_t operandB;
	word_t pcPlus1;
	word_t offset11;
	word_t offset7;
	word_t pcNext;
	aluFlags_t branchFlags;
	logic condTrue;
	execStage_t execNext;

	assign opcode = opcode_e'(instr[15:12]);
	assign cond = cond_e'(instr[11:8]);

	// Port A reads rn or the BX target and port B reads rm or the STR data
	assign readAddrA = instr[8:6];
	assign readAddrB = (opcode == OP_STR) ? instr[11:9] : instr[5:3];

	// Bypass the result being written back this cycle
	assign operandA = (fwdValid && fwdAddr == readAddrA) ? fwdData : readDataA;
	assign operandB = (fwdValid && fwdAddr == readAddrB) ? fwdData : readDataB;

	// Flags of the instruction in execute win over the stored ones
	assign branchFlags = flagsWillSet ? flagsNext : flags;

	always_comb begin
		case (cond)
			COND_EQ: condTrue = branchFlags.zero;
			COND_NE: condTrue = !branchFlags.zero;
			COND_CS: condTrue = branchFlags.carry;
			COND_CC: condTrue = !branchFlags.carry;
			COND_MI: condTrue = branchFlags.negative;
			COND_PL: condTrue = !branchFlags.negative;
			COND_VS: condTrue = branchFlags.overflow;
			COND_VC: condTrue = !branchFlags.overflow;
			default: condTrue = 1'b0;
		endcase
	end

	// Sign-extended branch offsets
	assign offset11 = {{(`CPU_WORD_W-11){instr[10]}}, instr[10:0]};
	assign offset7 = {{(`CPU_WORD_W-7){instr[6]}}, instr[6:0]};
	assign pcPlus1 = (pc + word_t'(1)) & pcMask;

	// Taken branches redirect the next PC with no bubble
	always_comb begin
		pcNext = pcPlus1;
		case (opcode)
			OP_B, OP_BL: pcNext = pc + offset11;
			OP_BC: begin
				if (condTrue) begin
					pcNext = pc + offset7;
				end
			end
			OP_BX: pcNext = operandA;
			default: ;
		endcase
	end

	// Decoder
	always_comb begin
		execNext = '0;
		execNext.valid = 1'b1;
		execNext.opA = operandA;
		execNext.opB = operandB;
		execNext.writeAddr = instr[11:9];
		execNext.link = pcPlus1;
		execNext.ctrl.wbSel = WB_ALU;
		case (opcode)
			OP_ADDI, OP_SUBI: begin
				execNext.ctrl.aluOp = (opcode == OP_ADDI) ? ALU_ADD : ALU_SUB;
				execNext.ctrl.bIsImm = 1'b1;
				execNext.imm = word_t'(instr[5:3]);
				execNext.ctrl.regWrite = 1'b1;
				execNext.ctrl.setFlags = 1'b1;
			end
			OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR: begin
				case (opcode)
					OP_ADD: execNext.ctrl.aluOp = ALU_ADD;
					OP_SUB: execNext.ctrl.aluOp = ALU_SUB;
					OP_AND: execNext.ctrl.aluOp = ALU_AND;
					OP_ORR: execNext.ctrl.aluOp = ALU_OR;
					default: execNext.ctrl.aluOp = ALU_XOR;
				endcase
				execNext.ctrl.regWrite = 1'b1;
				execNext.ctrl.setFlags = 1'b1;
			end
			// Shifts leave the flags alone
			OP_LSL, OP_LSR: begin
				execNext.ctrl.aluOp = (opcode == OP_LSL) ? ALU_SHL : ALU_SHR;
				execNext.ctrl.regWrite = 1'b1;
			end
			OP_MOVI: begin
				execNext.ctrl.aluOp = ALU_PASSB;
				execNext.ctrl.bIsImm = 1'b1;
				execNext.imm = word_t'(instr[7:0]);
				execNext.ctrl.regWrite = 1'b1;
				execNext.ctrl.wbSel = WB_IMM;
			end
			// Loads and stores add the offset to rn for the address
			OP_LDR, OP_STR: begin
				execNext.ctrl.aluOp = ALU_ADD;
				execNext.ctrl.bIsImm = 1'b1;
				execNext.imm = word_t'(instr[4:0]);
				execNext.ctrl.regWrite = (opcode == OP_LDR);
				execNext.ctrl.memWrite = (opcode == OP_STR);
				execNext.ctrl.wbSel = WB_MEM;
			end
			OP_BL: begin
				execNext.writeAddr = regAddr_t'(`CPU_LINK_REG);
				execNext.ctrl.regWrite = 1'b1;
				execNext.ctrl.wbSel = WB_LINK;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= word_t'(`CPU_PC_RESET);
			execStage <= '0;
		end else begin
			pc <= pcNext & pcMask;
			execStage <= execNext;
		end
	end

	// Idle execute stage after reset forwards nothing and leaves the flags alone
	execIdleAfterReset: assert property (@(posedge clk)
		reset |=> !execStage.valid && !fwdValid && !flagsWillSet);

endmodule

`default_nettype wire

//--- executeUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module executeUnit (
	input wire clk,
	input wire reset,
	input wire cpuPkg::execStage_t execStage,
	output logic regWrite,
	output cpuPkg::regAddr_t writeAddr,
	output cpuPkg::word_t writeData,
	output logic fwdValid,
	output cpuPkg::regAddr_t fwdAddr,
	output cpuPkg::word_t fwdData,
	output cpuPkg::aluFlags_t flagsNext,
	output logic flagsWillSet,
	output cpuPkg::aluFlags_t flags,
	output cpuPkg::word_t memAddr,
	output logic memWrite,
	output cpuPkg::word_t memWriteData,
	input wire cpuPkg::word_t memReadData,
	output cpuPkg::storeBus_t storeBus
);
	import cpuPkg::*;

	localparam int msb = `CPU_WORD_W - 1;
	// Data addresses wrap inside data memory
	localparam word_t dataMask = word_t'(`CPU_DMEM_DEPTH - 1);

	word_t operandA;
	word_t operandB;
	word_t shiftResult;
	word_t aluResult;
	logic [`CPU_WORD_W:0] sumExt;

	assign operandA = execStage.opA;
	assign operandB = execStage.ctrl.bIsImm ? execStage.imm : execStage.opB;

	// Log shifter, four stages for amounts 0 to 15
	always_comb begin
		shiftResult = operandA;
		for (int i = 0; i < 4; i++) begin
			if (operandB[i]) begin
				if (execStage.ctrl.aluOp == ALU_SHL) begin
					shiftResult = shiftResult << (1 << i);
				end else begin
					shiftResult = shiftResult >> (1 << i);
				end
			end
		end
	end

	// Subtract is add of the inverse plus one, carry means no borrow
	always_comb begin
		if (execStage.ctrl.aluOp == ALU_SUB) begin
			sumExt = {1'b0, operandA} + {1'b0, ~operandB} + 1'b1;
		end else begin
			sumExt = {1'b0, operandA} + {1'b0, operandB};
		end
	end

	always_comb begin
		case (execStage.ctrl.aluOp)
			ALU_ADD, ALU_SUB: aluResult = sumExt[msb:0];
			ALU_AND: aluResult = operandA & operandB;
			ALU_OR: aluResult = operandA | operandB;
			ALU_XOR: aluResult = operandA ^ operandB;
			ALU_SHL, ALU_SHR: aluResult = shiftResult;
			default: aluResult = operandB;
		endcase
	end

	// Logic ops clear carry and overflow
	always_comb begin
		flagsNext.negative = aluResult[msb];
		flagsNext.zero = (aluResult == '0);
		flagsNext.carry = 1'b0;
		flagsNext.overflow = 1'b0;
		case (execStage.ctrl.aluOp)
			ALU_ADD: begin
				flagsNext.carry = sumExt[`CPU_WORD_W];
				flagsNext.overflow = (operandA[msb] == operandB[msb]) &&
					(aluResult[msb] != operandA[msb]);
			end
			ALU_SUB: begin
				flagsNext.carry = sumExt[`CPU_WORD_W];
				flagsNext.overflow = (operandA[msb] != operandB[msb]) &&
					(aluResult[msb] != operandA[msb]);
			end
			default: ;
		endcase
	end

	assign flagsWillSet = execStage.valid && execStage.ctrl.setFlags;

	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (flagsWillSet) begin
			flags <= flagsNext;
		end
	end

	// Data memory side, store data is the raw rt word
	assign memAddr = aluResult & dataMask;
	assign memWrite = execStage.valid && execStage.ctrl.memWrite;
	assign memWriteData = execStage.opB;
	assign storeBus = '{strobe: memWrite, addr: memAddr, data: memWriteData};

	// Write-back source select
	always_comb begin
		case (execStage.ctrl.wbSel)
			WB_ALU: writeData = aluResult;
			WB_MEM: writeData = memReadData;
			WB_IMM: writeData = execStage.imm;
			default: writeData = execStage.link;
		endcase
	end

	assign regWrite = execStage.valid && execStage.ctrl.regWrite;
	assign writeAddr = execStage.writeAddr;

	// Same result goes back to decode for forwarding
	assign fwdValid = regWrite;
	assign fwdAddr = writeAddr;
	assign fwdData = writeData;

	// Decoder never marks a store as a register writer
	noStoreAndWrite: assert property (@(posedge clk) disable iff (reset)
		!(memWrite && regWrite));

endmodule

`default_nettype wire

//--- cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu (
	input wire clk,
	input wire reset,
	input wire progWrite,
	input wire cpuPkg::word_t progAddr,
	input wire cpuPkg::instr_t progData,
	output cpuPkg::word_t pc,
	output cpuPkg::storeBus_t storeBus
);
	import cpuPkg::*;

	localparam int imemAddrW = $clog2(`CPU_IMEM_DEPTH);
	localparam int dmemAddrW = $clog2(`CPU_DMEM_DEPTH);

	// Fetch and decode
	instr_t instr;
	regAddr_t readAddrA;
	regAddr_t readAddrB;
	word_t readDataA;
	word_t readDataB;
	execStage_t execStage;

	// Feedback from execute
	logic fwdValid;
	regAddr_t fwdAddr;
	word_t fwdData;
	aluFlags_t flagsNext;
	aluFlags_t flags;
	logic flagsWillSet;

	// Write-back and data memory
	logic regWrite;
	regAddr_t writeAddr;
	word_t writeData;
	logic memWrite;
	word_t memAddr;
	word_t memWriteData;
	word_t memReadData;

	// Program port loads code while reset is held
	wordRam #(.wordT(instr_t), .depth(`CPU_IMEM_DEPTH)) instructionMemory (
		.clk,
		.writeEnable(progWrite),
		.writeAddr(progAddr[imemAddrW-1:0]),
		.writeData(progData),
		.readAddr(pc[imemAddrW-1:0]),
		.readData(instr)
	);

	cpuControl controlUnit (
		.clk, .reset, .instr, .pc,
		.readAddrA, .readAddrB, .readDataA, .readDataB,
		.fwdValid, .fwdAddr, .fwdData,
		.flagsNext, .flagsWillSet, .flags,
		.execStage
	);

	regFile registers (
		.clk, .reset,
		.readAddrA, .readAddrB, .readDataA, .readDataB,
		.regWrite, .writeAddr, .writeData
	);

	executeUnit execUnit (
		.clk, .reset, .execStage,
		.regWrite, .writeAddr, .writeData,
		.fwdValid, .fwdAddr, .fwdData,
		.flagsNext, .flagsWillSet, .flags,
		.memAddr, .memWrite, .memWriteData, .memReadData,
		.storeBus
	);

	wordRam #(.wordT(word_t), .depth(`CPU_DMEM_DEPTH)) dataMemory (
		.clk,
		.writeEnable(memWrite),
		.writeAddr(memAddr[dmemAddrW-1:0]),
		.writeData(memWriteData),
		.readAddr(memAddr[dmemAddrW-1:0]),
		.readData(memReadData)
	);

endmodule

`default_nettype wire

//--- cpuTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpuTb;
	import cpuPkg::*;

	localparam int programCount = 4;
	localparam int resetCycles = 10;
	localparam int runCycles = 600;
	localparam int imemDepth = `CPU_IMEM_DEPTH;
	localparam int imemAddrW = $clog2(`CPU_IMEM_DEPTH);
	localparam int dmemAddrW = $clog2(`CPU_DMEM_DEPTH);
	// Reset, load and run per program, plus slack
	localparam int cycleLimit = programCount * (resetCycles + imemDepth + runCycles) + 100;
	localparam word_t pcMask = word_t'(`CPU_IMEM_DEPTH - 1);
	localparam word_t dataMask = word_t'(`CPU_DMEM_DEPTH - 1);

	logic clk;
	logic reset;
	logic progWrite;
	word_t progAddr;
	instr_t progData;
	word_t pc;
	storeBus_t storeBus;

	// Instruction-set model state
	instr_t progImage [0:imemDepth-1];
	word_t modelPc;
	word_t modelRegs [0:`CPU_REG_COUNT-1];
	word_t modelDmem [0:`CPU_DMEM_DEPTH-1];
	aluFlags_t modelFlags;
	storeBus_t lastStore;

	int pcErrors;
	int storeErrors;
	int cycleCount;

	cpu u_cpu (.clk, .reset, .progWrite, .progAddr, .progData, .pc, .storeBus);

	always #50 clk = ~clk;

	// Watchdog
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout, the run did not finish within %0d cycles", cycleLimit);
			$display("test failed");
			$finish;
		end
	end

	// One random legal instruction, small forward branch offsets
	function automatic instr_t randomInstr();
		regAddr_t rd;
		regAddr_t rn;
		regAddr_t rm;
		regAddr_t base;
		logic [10:0] off;
		logic [3:0] cond;
		int sel;
		rd = regAddr_t'($urandom_range(0, 7));
		rn = regAddr_t'($urandom_range(0, 7));
		rm = regAddr_t'($urandom_range(0, 7));
		// Few base registers so loads often hit earlier stores
		base = regAddr_t'($urandom_range(0, 1));
		off = 11'($urandom_range(1, 6));
		cond = 4'($urandom_range(0, 7));
		sel = int'($urandom_range(0, 19));
		case (sel)
			0, 1: return {OP_ADDI, rd, rn, rm, 3'b000};
			2: return {OP_SUBI, rd, rn, rm, 3'b000};
			3: return {OP_ADD, rd, rn, rm, 3'b000};
			4: return {OP_SUB, rd, rn, rm, 3'b000};
			5: return {OP_AND, rd, rn, rm, 3'b000};
			6: return {OP_ORR, rd, rn, rm, 3'b000};
			7: return {OP_EOR, rd, rn, rm, 3'b000};
			8: return {OP_LSL, rd, rn, rm, 3'b000};
			9: return {OP_LSR, rd, rn, rm, 3'b000};
			10, 11: return {OP_MOVI, rd, 1'b0, 8'($urandom_range(0, 255))};
			12, 13: return {OP_LDR, rd, base, 1'b0, 5'($urandom_range(0, 3))};
			14, 15: return {OP_STR, rd, base, 1'b0, 5'($urandom_range(0, 3))};
			16: return {OP_B, 1'b0, off};
			17: return {OP_BC, cond, 1'b0, off[6:0]};
			18: return {OP_BL, 1'b0, off};
			// Half the BX land on the link register
			default: return {OP_BX, 3'b000, rm[0] ? regAddr_t'(`CPU_LINK_REG) : rn, 6'b0};
		endcase
	endfunction

	// Runs the instruction at modelPc to completion
	task automatic modelStep(output storeBus_t store);
		instr_t ins;
		opcode_e op;
		regAddr_t rd;
		word_t a;
		word_t b;
		word_t result;
		word_t addr;
		word_t nextPc;
		int uSum;
		int sSum;
		logic taken;
		ins = progImage[modelPc[imemAddrW-1:0]];
		op = opcode_e'(ins[15:12]);
		rd = ins[11:9];
		a = modelRegs[ins[8:6]];
		b = modelRegs[ins[5:3]];
		store = '0;
		nextPc = (modelPc + word_t'(1)) & pcMask;
		case (op)
			OP_ADDI, OP_SUBI, OP_ADD, OP_SUB: begin
				if (op == OP_ADDI || op == OP_SUBI) begin
					b = word_t'(ins[5:3]);
				end
				// Carry on add is unsigned overflow, on subtract it means no borrow
				if (op == OP_ADDI || op == OP_ADD) begin
					uSum = int'(a) + int'(b);
					sSum = int'($signed(a)) + int'($signed(b));
					modelFlags.carry = (uSum > 65535);
				end else begin
					uSum = int'(a) - int'(b);
					sSum = int'($signed(a)) - int'($signed(b));
					modelFlags.carry = (a >= b);
				end
				result = word_t'(uSum);
				modelFlags.overflow = (sSum > 32767) || (sSum < -32768);
				modelFlags.negative = result[`CPU_WORD_W-1];
				modelFlags.zero = (result == '0);
				modelRegs[rd] = result;
			end
			OP_AND, OP_ORR, OP_EOR: begin
				if (op == OP_AND) begin
					result = a & b;
				end else if (op == OP_ORR) begin
					result = a | b;
				end else begin
					result = a ^ b;
				end
				modelFlags = '{negative: result[`CPU_WORD_W-1], zero: (result == '0),
					carry: 1'b0, overflow: 1'b0};
				modelRegs[rd] = result;
			end
			// Shift amount is the low nibble of rm, flags untouched
			OP_LSL: modelRegs[rd] = a << b[3:0];
			OP_LSR: modelRegs[rd] = a >> b[3:0];
			OP_MOVI: modelRegs[rd] = word_t'(ins[7:0]);
			OP_LDR: begin
				addr = (a + word_t'(ins[4:0])) & dataMask;
				modelRegs[rd] = modelDmem[addr[dmemAddrW-1:0]];
			end
			OP_STR: begin
				addr = (a + word_t'(ins[4:0])) & dataMask;
				modelDmem[addr[dmemAddrW-1:0]] = modelRegs[rd];
				store = '{strobe: 1'b1, addr: addr, data: modelRegs[rd]};
			end
			OP_B: nextPc = (modelPc + word_t'($signed(ins[10:0]))) & pcMask;
			OP_BC: begin
				case (cond_e'(ins[11:8]))
					COND_EQ: taken = modelFlags.zero;
					COND_NE: taken = !modelFlags.zero;
					COND_CS: taken = modelFlags.carry;
					COND_CC: taken = !modelFlags.carry;
					COND_MI: taken = modelFlags.negative;
					COND_PL: taken = !modelFlags.negative;
					COND_VS: taken = modelFlags.overflow;
					COND_VC: taken = !modelFlags.overflow;
					default: taken = 1'b0;
				endcase
				if (taken) begin
					nextPc = (modelPc + word_t'($signed(ins[6:0]))) & pcMask;
				end
			end
			OP_BL: begin
				modelRegs[`CPU_LINK_REG] = nextPc;
				nextPc = (modelPc + word_t'($signed(ins[10:0]))) & pcMask;
			end
			OP_BX: nextPc = a & pcMask;
			default: ;
		endcase
		modelPc = nextPc;
	endtask

	task automatic checkPc(input word_t actual, input word_t expected);
		if (actual !== expected) begin
			pcErrors++;
			$display("** Error pc: got %h, expected %h at %0t", actual, expected, $time);
		end
	endtask

	// Address and data only matter while a store is expected
	task automatic checkStore(input storeBus_t actual, input storeBus_t expected);
		logic bad;
		bad = expected.strobe ? (actual !== expected) : (actual.strobe !== 1'b0);
		if (bad) begin
			storeErrors++;
			$display("** Error storeBus: got %h, expected %h at %0t", actual, expected, $time);
		end
	endtask

	initial begin
		void'($urandom(32'h6a0082cc));
		clk = 1'b0;
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		// Data memory is cleared once and survives resets
		for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
			modelDmem[i] = '0;
		end
		for (int p = 0; p < programCount; p++) begin
			repeat (resetCycles) @(posedge clk);
			// Random body, then a store of every register
			for (int i = 0; i < imemDepth; i++) begin
				if (i >= imemDepth - `CPU_REG_COUNT) begin
					progImage[i] = {OP_STR, 3'(i), 3'd0, 1'b0, 5'(i)};
				end else begin
					progImage[i] = randomInstr();
				end
			end
			for (int i = 0; i < imemDepth; i++) begin
				@(posedge clk);
				progWrite <= 1'b1;
				progAddr <= word_t'(i);
				progData <= progImage[i];
			end
			@(posedge clk);
			progWrite <= 1'b0;
			reset <= 1'b0;
			modelPc = word_t'(`CPU_PC_RESET);
			modelFlags = '0;
			lastStore = '0;
			for (int r = 0; r < `CPU_REG_COUNT; r++) begin
				modelRegs[r] = '0;
			end
			// Sample mid-cycle, stores show one cycle after their fetch
			for (int c = 0; c < runCycles; c++) begin
				@(negedge clk);
				checkPc(pc, modelPc);
				checkStore(storeBus, lastStore);
				modelStep(lastStore);
			end
			// Last fetched instruction still executes under the new reset
			@(posedge clk);
			reset <= 1'b1;
			@(negedge clk);
			checkStore(storeBus, lastStore);
		end
		$display("Errors: pc %0d, storeBus %0d, total %0d", pcErrors, storeErrors,
			pcErrors + storeErrors);
		if (pcErrors + storeErrors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
cpuPkg.sv
wordRam.sv
regFile.sv
cpuControl.sv
executeUnit.sv
cpu.sv
cpuTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cpuTb -Mdir obj_dir -f compile.f
./obj_dir/VcpuTb > sim.log
cat sim.log
if grep -q "test failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failures"
